// ==== logic/md_defs.svh ====
/*
 * Width, half-word slice and divider step macros
 * for the RV32M multiply/divide unit
 */
`ifndef MD_DEFS_SVH
`define MD_DEFS_SVH

// Operand and result width, fixed by RV32
`define MD_XLEN 32

// Half-word width seen by the 16x16 multiplier
`define MD_HALF 16
`define MD_OP_LO 15:0
`define MD_OP_HI 31:16

// Compare-subtract steps before the last quotient bit
`define MD_DIV_STEPS 31

`endif

// ==== logic/md_pkg.sv ====
/*
 * Operation encoding and request struct shared by
 * the multiply/divide unit and its engines
 */
`include "md_defs.svh"

package md_pkg;

  // Encoding equals funct3, top bit selects the divider
  typedef enum logic [2:0] {
    MD_MUL    = 3'd0,
    MD_MULH   = 3'd1,
    MD_MULHSU = 3'd2,
    MD_MULHU  = 3'd3,
    MD_DIV    = 3'd4,
    MD_DIVU   = 3'd5,
    MD_REM    = 3'd6,
    MD_REMU   = 3'd7
  } md_op_e;

  // One request, 67 bits
  typedef struct packed {
    md_op_e              op;
    logic [`MD_XLEN-1:0] op_a;
    logic [`MD_XLEN-1:0] op_b;
  } md_req_t;

endpackage

// ==== logic/md_mult.sv ====
/*
 * Sequential 16x16 multiply-accumulate engine for MUL, MULH,
 * MULHSU and MULHU, one 17x17 signed multiplier stepped over four phases
 */
`timescale 1ns/1ps
`include "md_defs.svh"

module md_mult import md_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  md_req_t             req_i,
  output logic                done_o,
  output logic [`MD_XLEN-1:0] result_o
);

  typedef enum logic [2:0] {
    IDLE, ALBL, ALBH, AHBL, AHBH
  } mult_state_e;

  mult_state_e state_q, state_d;

  logic [`MD_HALF-1:0]        mul_op_a;
  logic [`MD_HALF-1:0]        mul_op_b;
  logic                       mul_sign_a;
  logic                       mul_sign_b;
  logic [`MD_XLEN+1:0]        accum;
  logic signed [`MD_XLEN+1:0] mac_res;
  logic [`MD_XLEN+1:0]        acc_q, acc_d;
  logic                       done_q, done_d;
  logic                       is_mul;
  logic                       signed_a;
  logic                       signed_b;

  assign is_mul   = (req_i.op == MD_MUL);
  assign signed_a = (req_i.op == MD_MULH) | (req_i.op == MD_MULHSU);
  assign signed_b = (req_i.op == MD_MULH);

  // The two top bits of the full sum always agree, so 34 bits are enough
  assign mac_res = $signed({mul_sign_a, mul_op_a}) * $signed({mul_sign_b, mul_op_b})
                 + $signed(accum);

  always_comb begin
    state_d    = state_q;
    mul_op_a   = req_i.op_a[`MD_OP_LO];
    mul_op_b   = req_i.op_b[`MD_OP_LO];
    mul_sign_a = 1'b0;
    mul_sign_b = 1'b0;
    accum      = '0;
    acc_d      = acc_q;
    done_d     = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (start_i) begin
          state_d = ALBL;
        end
      end

      ALBL: begin
        // Low halves, always unsigned
        acc_d   = mac_res;
        state_d = ALBH;
      end

      ALBH: begin
        mul_op_b   = req_i.op_b[`MD_OP_HI];
        mul_sign_b = signed_b & req_i.op_b[`MD_XLEN-1];
        accum      = {{(`MD_HALF+2){1'b0}}, acc_q[`MD_OP_HI]};
        if (is_mul) begin
          acc_d = {2'b00, mac_res[`MD_OP_LO], acc_q[`MD_OP_LO]};
        end else begin
          acc_d = mac_res;
        end
        state_d = AHBL;
      end

      AHBL: begin
        mul_op_a   = req_i.op_a[`MD_OP_HI];
        mul_sign_a = signed_a & req_i.op_a[`MD_XLEN-1];
        if (is_mul) begin
          // Low word complete, upper product not needed
          accum   = {{(`MD_HALF+2){1'b0}}, acc_q[`MD_OP_HI]};
          acc_d   = {2'b00, mac_res[`MD_OP_LO], acc_q[`MD_OP_LO]};
          done_d  = 1'b1;
          state_d = IDLE;
        end else begin
          accum   = acc_q;
          acc_d   = mac_res;
          state_d = AHBH;
        end
      end

      AHBH: begin
        mul_op_a   = req_i.op_a[`MD_OP_HI];
        mul_op_b   = req_i.op_b[`MD_OP_HI];
        mul_sign_a = signed_a & req_i.op_a[`MD_XLEN-1];
        mul_sign_b = signed_b & req_i.op_b[`MD_XLEN-1];
        // Carry in the partial sum shifted down, sign extended when signed
        accum   = {{`MD_HALF{signed_a & acc_q[`MD_XLEN+1]}}, acc_q[`MD_XLEN+1:`MD_HALF]};
        acc_d   = mac_res;
        done_d  = 1'b1;
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    acc_q <= acc_d;
  end

  assign done_o   = done_q;
  assign result_o = acc_q[`MD_XLEN-1:0];

  assert property (@(posedge clk_i) disable iff (!rst_ni) !$isunknown(state_q))
    else $error("md_mult: phase state is unknown");

endmodule

// ==== logic/md_div.sv ====
/*
 * Restoring long divider for DIV, DIVU, REM and REMU with
 * absolute-value and sign-correction steps and a divide-by-zero path
 */
`timescale 1ns/1ps
`include "md_defs.svh"

module md_div import md_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  md_req_t             req_i,
  output logic                done_o,
  output logic [`MD_XLEN-1:0] result_o
);

  typedef enum logic [2:0] {
    IDLE, ABS_A, ABS_B, COMP, LAST, CHANGE_SIGN, FINISH
  } div_state_e;

  div_state_e state_q, state_d;

  logic [4:0]          cnt_q, cnt_d;
  logic                check_q;
  logic                done_q, done_d;
  logic                b_zero_q;
  logic [`MD_XLEN-1:0] num_q, num_d;
  logic [`MD_XLEN-1:0] den_q, den_d;
  logic [`MD_XLEN-1:0] quo_q, quo_d;
  logic [`MD_XLEN-1:0] res_q, res_d;
  logic [`MD_XLEN:0]   rem_q, rem_d;
  logic [`MD_XLEN:0]   sub_a, sub_b, sub_res;
  logic                greater_equal;
  logic [`MD_XLEN-1:0] next_rem;
  logic [`MD_XLEN-1:0] next_quo;
  logic [`MD_XLEN-1:0] one_shift;
  logic                signed_op;
  logic                is_rem;
  logic                sign_a;
  logic                sign_b;

  assign signed_op = (req_i.op == MD_DIV) | (req_i.op == MD_REM);
  assign is_rem    = (req_i.op == MD_REM) | (req_i.op == MD_REMU);
  assign sign_a    = signed_op & req_i.op_a[`MD_XLEN-1];
  assign sign_b    = signed_op & req_i.op_b[`MD_XLEN-1];

  // Shared subtractor for negation and compare-subtract
  assign sub_res = sub_a - sub_b;

  // A partial remainder with bit 32 set is always above the divisor
  assign greater_equal = rem_q[`MD_XLEN] | ~sub_res[`MD_XLEN];
  assign one_shift     = {{(`MD_XLEN-1){1'b0}}, 1'b1} << cnt_q;
  assign next_rem      = greater_equal ? sub_res[`MD_XLEN-1:0] : rem_q[`MD_XLEN-1:0];
  assign next_quo      = greater_equal ? (quo_q | one_shift) : quo_q;

  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    num_d   = num_q;
    den_d   = den_q;
    quo_d   = quo_q;
    rem_d   = rem_q;
    res_d   = res_q;
    sub_a   = '0;
    sub_b   = {1'b0, req_i.op_b};
    done_d  = 1'b0;

    unique case (state_q)
      IDLE: begin
        if (check_q) begin
          cnt_d = 5'(`MD_DIV_STEPS);
          if (b_zero_q) begin
            // Quotient all ones, remainder is the dividend
            res_d   = is_rem ? req_i.op_a : '1;
            state_d = FINISH;
          end else begin
            state_d = ABS_A;
          end
        end
      end

      ABS_A: begin
        sub_b   = {1'b0, req_i.op_a};
        num_d   = sign_a ? sub_res[`MD_XLEN-1:0] : req_i.op_a;
        quo_d   = '0;
        state_d = ABS_B;
      end

      ABS_B: begin
        den_d   = sign_b ? sub_res[`MD_XLEN-1:0] : req_i.op_b;
        rem_d   = {{`MD_XLEN{1'b0}}, num_q[`MD_XLEN-1]};
        state_d = COMP;
      end

      COMP: begin
        sub_a   = rem_q;
        sub_b   = {1'b0, den_q};
        cnt_d   = cnt_q - 5'd1;
        quo_d   = next_quo;
        // Bring down the next dividend bit
        rem_d   = {next_rem, num_q[cnt_d]};
        state_d = (cnt_q == 5'd1) ? LAST : COMP;
      end

      LAST: begin
        sub_a   = rem_q;
        sub_b   = {1'b0, den_q};
        res_d   = is_rem ? next_rem : next_quo;
        state_d = CHANGE_SIGN;
      end

      CHANGE_SIGN: begin
        sub_b = {1'b0, res_q};
        if (is_rem ? sign_a : (sign_a ^ sign_b)) begin
          res_d = sub_res[`MD_XLEN-1:0];
        end
        state_d = FINISH;
      end

      FINISH: begin
        done_d  = 1'b1;
        state_d = IDLE;
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
      cnt_q   <= '0;
      check_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      check_q <= start_i;
      done_q  <= done_d;
    end
  end

  always_ff @(posedge clk_i) begin
    num_q <= num_d;
    den_q <= den_d;
    quo_q <= quo_d;
    rem_q <= rem_d;
    res_q <= res_d;
    if (start_i) begin
      b_zero_q <= (req_i.op_b == '0);
    end
  end

  assign done_o   = done_q;
  assign result_o = res_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_q inside {IDLE, ABS_A, ABS_B, COMP, LAST, CHANGE_SIGN, FINISH})
    else $error("md_div: illegal state encoding");

endmodule

// ==== logic/md_unit.sv ====
/*
 * Multiply/divide unit top level: request capture, dispatch to
 * the multiply or divide engine, registered one-cycle response
 */
`timescale 1ns/1ps
`include "md_defs.svh"

module md_unit import md_pkg::*; (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  md_req_t             req_i,
  output logic                req_ready_o,
  output logic                rsp_valid_o,
  output logic [`MD_XLEN-1:0] rsp_result_o
);

  md_req_t             req_q;
  logic                busy_q;
  logic                start_q;
  logic                rsp_valid_q;
  logic [`MD_XLEN-1:0] rsp_result_q;
  logic                accept;
  logic                is_div;
  logic                mult_done, div_done;
  logic [`MD_XLEN-1:0] mult_result, div_result;

  assign accept = req_valid_i & req_ready_o;
  // Top funct3 bit marks the division class
  assign is_div = req_q.op[2];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q      <= 1'b0;
      start_q     <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      start_q     <= accept;
      rsp_valid_q <= mult_done | div_done;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (rsp_valid_q) begin
        // Free again once the response pulse has gone out
        busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q <= req_i;
    end
    if (mult_done) begin
      rsp_result_q <= mult_result;
    end else if (div_done) begin
      rsp_result_q <= div_result;
    end
  end

  md_mult md_mult_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_q & ~is_div),
    .req_i    (req_q),
    .done_o   (mult_done),
    .result_o (mult_result)
  );

  md_div md_div_inst (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start_i  (start_q & is_div),
    .req_i    (req_q),
    .done_o   (div_done),
    .result_o (div_result)
  );

  assign req_ready_o  = ~busy_q;
  assign rsp_valid_o  = rsp_valid_q;
  assign rsp_result_o = rsp_result_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni) (mult_done | div_done) |-> busy_q)
    else $error("md_unit: engine done while no operation in flight");

endmodule

// ==== testbench/md_checker.sv ====
/*
 * Response checker: pairs accepted requests with
 * response pulses and compares against the data file
 */
`timescale 1ns/1ps
`include "md_defs.svh"

module md_checker import md_pkg::*; #(
  parameter int NUM_VECTORS = 1
) (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                req_valid_i,
  input  logic                req_ready_i,
  input  logic                rsp_valid_i,
  input  logic [`MD_XLEN-1:0] rsp_result_i,
  output int                  done_count_o,
  output int                  error_count_o
);

  logic [`MD_XLEN-1:0] vec_mem [0:4*NUM_VECTORS-1];
  int                  pending_q [$];
  int                  accept_count = 0;
  int                  done_count = 0;
  int                  error_count = 0;
  logic                in_flight = 1'b0;
  logic                reset_seen = 1'b0;

  initial begin
    $readmemh("testbench/md_testdata.hex", vec_mem);
  end

  assign done_count_o  = done_count;
  assign error_count_o = error_count;

  // Ports are sampled mid-cycle, away from the edges that change them
  always @(negedge clk_i) begin
    int     idx;
    md_op_e op;
    if (rst_ni) begin
      if (!reset_seen) begin
        reset_seen = 1'b1;
        if (!req_ready_i || rsp_valid_i) begin
          $display("Handshake error: after reset req_ready_o is %0b and rsp_valid_o is %0b",
                   req_ready_i, rsp_valid_i);
          error_count++;
        end
      end
      if (rsp_valid_i) begin
        if (!in_flight) begin
          $display("Handshake error: rsp_valid_o pulsed with no request in flight");
          error_count++;
        end else begin
          idx = pending_q.pop_front();
          op  = md_op_e'(vec_mem[4*idx][2:0]);
          in_flight = 1'b0;
          done_count++;
          if (rsp_result_i !== vec_mem[4*idx+3]) begin
            $display("** Error test %0d %s: rsp_result_o expected 0x%08h actual 0x%08h",
                     idx, op.name(), vec_mem[4*idx+3], rsp_result_i);
            error_count++;
          end else begin
            $display("Test %0d %s a=0x%08h b=0x%08h result=0x%08h ok", idx, op.name(),
                     vec_mem[4*idx+1], vec_mem[4*idx+2], rsp_result_i);
          end
        end
      end else if (in_flight && req_ready_i) begin
        $display("Handshake error: req_ready_o high while a request is in flight");
        error_count++;
      end else if (!in_flight && !req_ready_i) begin
        $display("Handshake error: req_ready_o low with no request in flight");
        error_count++;
      end
      if (req_valid_i && req_ready_i) begin
        pending_q.push_back(accept_count);
        accept_count++;
        in_flight = 1'b1;
      end
    end
  end

endmodule

// ==== testbench/tb_md_unit.sv ====
/*
 * Testbench top: clock, reset, file-driven requests
 * to the multiply/divide unit and the closing report
 */
`timescale 1ns/1ps
`include "md_defs.svh"

module tb_md_unit import md_pkg::*; ();

  localparam int NUM_VECTORS = 22;
  localparam int ACCEPT_TIMEOUT = 100;
  localparam int RESPONSE_TIMEOUT = 100;

  logic                clk;
  logic                rst_n;
  logic                req_valid;
  md_req_t             req;
  logic                req_ready;
  logic                rsp_valid;
  logic [`MD_XLEN-1:0] rsp_result;
  int                  done_count;
  int                  error_count;
  logic                timed_out;
  logic [`MD_XLEN-1:0] vec_mem [0:4*NUM_VECTORS-1];

  always #4 clk = ~clk;

  md_unit md_unit_inst (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .req_valid_i  (req_valid),
    .req_i        (req),
    .req_ready_o  (req_ready),
    .rsp_valid_o  (rsp_valid),
    .rsp_result_o (rsp_result)
  );

  md_checker #(.NUM_VECTORS(NUM_VECTORS)) md_checker_inst (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .req_valid_i   (req_valid),
    .req_ready_i   (req_ready),
    .rsp_valid_i   (rsp_valid),
    .rsp_result_i  (rsp_result),
    .done_count_o  (done_count),
    .error_count_o (error_count)
  );

  // Called on a rising edge, returns on the accept edge
  task automatic send_request(input int idx);
    md_req_t vec_req;
    int      wait_cycles;
    vec_req.op   = md_op_e'(vec_mem[4*idx][2:0]);
    vec_req.op_a = vec_mem[4*idx+1];
    vec_req.op_b = vec_mem[4*idx+2];
    req_valid <= 1'b1;
    req       <= vec_req;
    wait_cycles = 0;
    @(negedge clk);
    while (!req_ready && !timed_out) begin
      wait_cycles++;
      if (wait_cycles > ACCEPT_TIMEOUT) begin
        $display("Timeout: request %0d was not accepted within %0d cycles", idx, ACCEPT_TIMEOUT);
        timed_out = 1'b1;
      end else begin
        @(negedge clk);
      end
    end
    @(posedge clk);
    req_valid <= 1'b0;
  endtask

  // Checker counts on the falling edge, so the count is stable here
  task automatic wait_response(input int idx, input int prev_count);
    int wait_cycles;
    wait_cycles = 0;
    while (done_count == prev_count && !timed_out) begin
      @(posedge clk);
      wait_cycles++;
      if (done_count == prev_count && wait_cycles >= RESPONSE_TIMEOUT) begin
        $display("Timeout: no response to request %0d after %0d cycles", idx, RESPONSE_TIMEOUT);
        timed_out = 1'b1;
      end
    end
  endtask

  initial begin
    int prev_count;
    clk       = 1'b0;
    rst_n     = 1'b0;
    req_valid = 1'b0;
    req       = '0;
    timed_out = 1'b0;
    $readmemh("testbench/md_testdata.hex", vec_mem);
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_VECTORS && !timed_out; i++) begin
      prev_count = done_count;
      send_request(i);
      wait_response(i, prev_count);
      // Idle gap after every third vector, the rest go back to back
      if (i % 3 == 2) begin
        repeat (2) @(posedge clk);
      end
    end
    // Room for a stray second pulse to be caught
    repeat (4) @(posedge clk);
    $display("Summary: %0d of %0d tests completed, %0d errors", done_count, NUM_VECTORS,
             error_count);
    if (!timed_out && error_count == 0 && done_count == NUM_VECTORS) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

// ==== testbench/md_testdata.hex ====
// Columns: op (funct3), operand a, operand b, expected result
// op 0..3 MUL MULH MULHSU MULHU, op 4..7 DIV DIVU REM REMU
0 00000000 12345678 00000000
0 ffffffff ffffffff 00000001
0 00012345 00006789 75cca2ed
0 80000000 ffffffff 80000000
1 80000000 80000000 40000000
1 ffffffff 00000005 ffffffff
2 ffffffff ffffffff ffffffff
2 00000002 80000000 00000001
3 ffffffff ffffffff fffffffe
4 00000014 00000006 00000003
4 ffffffec 00000006 fffffffd
4 00000014 fffffffa fffffffd
4 ffffffec fffffffa 00000003
4 80000000 ffffffff 80000000
4 00000007 00000000 ffffffff
5 ffffffec 00000006 2aaaaaa7
5 00001234 00000000 ffffffff
6 ffffffec 00000006 fffffffe
6 80000000 ffffffff 00000000
6 fffffff9 00000000 fffffff9
7 ffffffec 00000006 00000002
7 00000064 00000000 00000064

// ==== sources.f ====
+incdir+logic
logic/md_pkg.sv
logic/md_mult.sv
logic/md_div.sv
logic/md_unit.sv
testbench/md_checker.sv
testbench/tb_md_unit.sv

// ==== Makefile ====
# Verilator flow for the multiply/divide unit testbench

VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0
TOP        ?= tb_md_unit
FILELIST   ?= sources.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

# The run passes only if the pass message reaches the log
sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q '^\*\*\* PASSED \*\*\*$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
